// File: common/hb_defs.svh
`ifndef HB_DEFS_SVH
`define HB_DEFS_SVH

// high-speed bus address map

// data RAM domain, 4 bytes per word
`define HB_DATA_RAM_BASE 32'h0001_0000
`define HB_RAM_DEPTH     256
`define HB_DATA_RAM_SIZE (4 * `HB_RAM_DEPTH)

// local peripheral domain, four 64-byte slave windows
`define HB_LOCAL_BASE    32'h0002_0000
`define HB_LOCAL_SIZE    256

// external interrupt sources on the controller
`define HB_EINT_NUM      8

`endif

// File: common/hb_bus_pkg.sv
package hb_bus_pkg;

  // register view of an address inside the local domain
  // slave id picks a 64-byte window, reg_idx a word in it
  typedef struct packed {
    logic [23:0] region;
    logic [1:0]  slave;
    logic [3:0]  reg_idx;
    logic [1:0]  byte_off;
  } hb_local_addr_t;

  // one bus address, read flat or as local fields
  typedef union packed {
    logic [31:0]    flat;
    hb_local_addr_t loc;
  } hb_addr_u;

  // store width from the load/store unit
  typedef enum logic [1:0] {
    W_BYTE = 2'd0,
    W_HALF = 2'd1,
    W_WORD = 2'd2
  } hb_width_e;

endpackage

// File: common/hb_map_pkg.sv
package hb_map_pkg;

  // address domains on the bus
  typedef enum logic [1:0] {
    DOM_RAM   = 2'd0,
    DOM_LOCAL = 2'd1,
    DOM_NONE  = 2'd2
  } hb_domain_e;

  // slaves inside the local domain, in window order
  typedef enum logic [1:0] {
    SLV_LED   = 2'd0,
    SLV_TIMER = 2'd1,
    SLV_EINT  = 2'd2
  } hb_slave_e;

endpackage

// File: verilog/hb_addr_decode.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module hb_addr_decode (
  input  logic                   hb_clk_i,
  input  logic                   rst_n_i,
  input  logic                   read_i,
  input  logic                   write_i,
  input  logic [31:0]            raddr_i,
  input  logic [31:0]            waddr_i,
  output logic                   ram_rd_sel_o,
  output logic                   ram_wr_sel_o,
  output logic                   loc_rd_sel_o,
  output logic                   loc_wr_sel_o,
  output hb_map_pkg::hb_slave_e  rd_slave_o,
  output hb_map_pkg::hb_slave_e  wr_slave_o,
  output hb_map_pkg::hb_domain_e rd_dom_o,
  output logic                   none_rd_o
);
  import hb_bus_pkg::*;
  import hb_map_pkg::*;

  hb_addr_u   raddr_u, waddr_u;
  hb_domain_e rd_dom_c, wr_dom_c;

  function automatic hb_domain_e domain_of(input logic [31:0] addr);
    if (addr >= `HB_DATA_RAM_BASE && addr < `HB_DATA_RAM_BASE + `HB_DATA_RAM_SIZE)
      return DOM_RAM;
    if (addr >= `HB_LOCAL_BASE && addr < `HB_LOCAL_BASE + `HB_LOCAL_SIZE)
      return DOM_LOCAL;
    return DOM_NONE;
  endfunction

  assign raddr_u  = raddr_i;
  assign waddr_u  = waddr_i;
  assign rd_dom_c = domain_of(raddr_u.flat);
  assign wr_dom_c = domain_of(waddr_u.flat);

  assign ram_rd_sel_o = read_i && (rd_dom_c == DOM_RAM);
  assign loc_rd_sel_o = read_i && (rd_dom_c == DOM_LOCAL);
  assign none_rd_o    = read_i && (rd_dom_c == DOM_NONE);
  assign ram_wr_sel_o = write_i && (wr_dom_c == DOM_RAM);
  assign loc_wr_sel_o = write_i && (wr_dom_c == DOM_LOCAL);

  // window 3 is unused, the local domain answers it with zero
  assign rd_slave_o = hb_slave_e'(raddr_u.loc.slave);
  assign wr_slave_o = hb_slave_e'(waddr_u.loc.slave);

  // remembers whose finish and data the result mux waits for
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_dom_o <= DOM_NONE;
    end else if (read_i) begin
      rd_dom_o <= rd_dom_c;
    end
  end

endmodule

// File: verilog/hb_data_ram.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module hb_data_ram (
  input  logic                  hb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  rd_sel_i,
  input  logic                  wr_sel_i,
  input  logic [31:0]           raddr_i,
  input  logic [31:0]           waddr_i,
  input  logic [31:0]           wdata_i,
  input  hb_bus_pkg::hb_width_e write_width_i,
  output logic [31:0]           rdata_o,
  output logic                  read_finish_o
);
  import hb_bus_pkg::*;

  localparam int AW = $clog2(`HB_RAM_DEPTH);

  logic [31:0] mem [`HB_RAM_DEPTH];
  hb_addr_u    raddr_u, waddr_u;
  logic [3:0]  wr_be;
  logic [31:0] wr_lane;

  assign raddr_u = raddr_i;
  assign waddr_u = waddr_i;

  // byte enables and lane placement from width and offset
  always_comb begin
    case (write_width_i)
      W_BYTE: begin
        wr_be   = 4'b0001 << waddr_u.loc.byte_off;
        wr_lane = wdata_i << {waddr_u.loc.byte_off, 3'b000};
      end
      W_HALF: begin
        wr_be   = 4'b0011 << {waddr_u.loc.byte_off[1], 1'b0};
        wr_lane = wdata_i << {waddr_u.loc.byte_off[1], 4'b0000};
      end
      default: begin
        wr_be   = 4'b1111;
        wr_lane = wdata_i;
      end
    endcase
  end

  always_ff @(posedge hb_clk_i) begin
    if (wr_sel_i) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_be[i])
          mem[waddr_u.flat[AW+1:2]][8*i +: 8] <= wr_lane[8*i +: 8];
      end
    end
  end

  // data captured only at the request edge, held through the data cycle
  always_ff @(posedge hb_clk_i) begin
    if (rd_sel_i && !read_finish_o)
      rdata_o <= mem[raddr_u.flat[AW+1:2]];
  end

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      read_finish_o <= 1'b0;
    end else begin
      read_finish_o <= rd_sel_i && !read_finish_o;
    end
  end

endmodule

// File: hb_local/system_timer.sv
`timescale 1ns/10ps

module system_timer (
  input  logic        hb_clk_i,
  input  logic        rst_n_i,
  input  logic        wr_en_i,
  input  logic [3:0]  reg_i,
  input  logic [31:0] wdata_i,
  input  logic        timer_tick_i,
  output logic [31:0] rdata_comb_o,
  output logic        mtimer_int_o
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        mtime_wr;

  assign mtime_wr = wr_en_i && (reg_i == 4'd0 || reg_i == 4'd1);

  // software write to mtime wins over a tick on the same edge
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime <= 64'h0;
    end else if (mtime_wr) begin
      if (reg_i == 4'd0)
        mtime[31:0] <= wdata_i;
      else
        mtime[63:32] <= wdata_i;
    end else if (timer_tick_i) begin
      mtime <= mtime + 64'd1;
    end
  end

  // all ones keeps the interrupt quiet until software sets a compare
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtimecmp <= '1;
    end else if (wr_en_i && reg_i == 4'd2) begin
      mtimecmp[31:0] <= wdata_i;
    end else if (wr_en_i && reg_i == 4'd3) begin
      mtimecmp[63:32] <= wdata_i;
    end
  end

  always_comb begin
    case (reg_i)
      4'd0:    rdata_comb_o = mtime[31:0];
      4'd1:    rdata_comb_o = mtime[63:32];
      4'd2:    rdata_comb_o = mtimecmp[31:0];
      4'd3:    rdata_comb_o = mtimecmp[63:32];
      default: rdata_comb_o = 32'h0;
    endcase
  end

  assign mtimer_int_o = (mtime >= mtimecmp);

endmodule

// File: hb_local/eint_ctrl.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module eint_ctrl (
  input  logic                    hb_clk_i,
  input  logic                    rst_n_i,
  input  logic                    wr_en_i,
  input  logic [3:0]              reg_i,
  input  logic [31:0]             wdata_i,
  input  logic [`HB_EINT_NUM-1:0] irq_src_i,
  output logic [31:0]             rdata_comb_o,
  output logic                    mextern_int_o,
  output logic [2:0]              mextern_int_id_o
);

  localparam int N    = `HB_EINT_NUM;
  localparam int ID_W = $clog2(N);

  logic [N-1:0] pending, enable, active, clr_mask;

  assign clr_mask = (wr_en_i && reg_i == 4'd0) ? wdata_i[N-1:0] : '0;

  // a source still high sets its bit again over the clear
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending <= '0;
      enable  <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | irq_src_i;
      if (wr_en_i && reg_i == 4'd1)
        enable <= wdata_i[N-1:0];
    end
  end

  assign active        = pending & enable;
  assign mextern_int_o = |active;

  // lowest pending id wins
  always_comb begin
    mextern_int_id_o = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (active[i])
        mextern_int_id_o = ID_W'(i);
    end
  end

  always_comb begin
    case (reg_i)
      4'd0:    rdata_comb_o = 32'(pending);
      4'd1:    rdata_comb_o = 32'(enable);
      4'd2:    rdata_comb_o = {mextern_int_o, {(31 - ID_W){1'b0}}, mextern_int_id_o};
      default: rdata_comb_o = 32'h0;
    endcase
  end

endmodule

// File: hb_local/hb_local_domain.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module hb_local_domain (
  input  logic                    hb_clk_i,
  input  logic                    rst_n_i,
  input  logic                    rd_sel_i,
  input  logic                    wr_sel_i,
  input  hb_map_pkg::hb_slave_e   rd_slave_i,
  input  hb_map_pkg::hb_slave_e   wr_slave_i,
  input  logic [31:0]             raddr_i,
  input  logic [31:0]             waddr_i,
  input  logic [31:0]             wdata_i,
  input  logic                    timer_tick_i,
  input  logic [`HB_EINT_NUM-1:0] irq_src_i,
  output logic [31:0]             rdata_o,
  output logic                    read_finish_o,
  output logic [7:0]              led_o,
  output logic                    mtimer_int_o,
  output logic                    mextern_int_o,
  output logic [2:0]              mextern_int_id_o
);
  import hb_bus_pkg::*;
  import hb_map_pkg::*;

  hb_addr_u    raddr_u, waddr_u;
  logic        led_wr, tmr_wr, eint_wr;
  logic [3:0]  tmr_reg, eint_reg;
  logic [31:0] tmr_rdata, eint_rdata, rd_mux;

  assign raddr_u = raddr_i;
  assign waddr_u = waddr_i;

  // write fan-out by slave window
  assign led_wr  = wr_sel_i && (wr_slave_i == SLV_LED);
  assign tmr_wr  = wr_sel_i && (wr_slave_i == SLV_TIMER);
  assign eint_wr = wr_sel_i && (wr_slave_i == SLV_EINT);

  // each slave has one register index, a write takes it over for that cycle
  assign tmr_reg  = tmr_wr ? waddr_u.loc.reg_idx : raddr_u.loc.reg_idx;
  assign eint_reg = eint_wr ? waddr_u.loc.reg_idx : raddr_u.loc.reg_idx;

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o <= 8'h0;
    end else if (led_wr) begin
      led_o <= wdata_i[7:0];
    end
  end

  system_timer u_system_timer (
    .hb_clk_i     (hb_clk_i),
    .rst_n_i      (rst_n_i),
    .wr_en_i      (tmr_wr),
    .reg_i        (tmr_reg),
    .wdata_i      (wdata_i),
    .timer_tick_i (timer_tick_i),
    .rdata_comb_o (tmr_rdata),
    .mtimer_int_o (mtimer_int_o)
  );

  eint_ctrl u_eint_ctrl (
    .hb_clk_i         (hb_clk_i),
    .rst_n_i          (rst_n_i),
    .wr_en_i          (eint_wr),
    .reg_i            (eint_reg),
    .wdata_i          (wdata_i),
    .irq_src_i        (irq_src_i),
    .rdata_comb_o     (eint_rdata),
    .mextern_int_o    (mextern_int_o),
    .mextern_int_id_o (mextern_int_id_o)
  );

  always_comb begin
    case (rd_slave_i)
      SLV_LED:   rd_mux = {24'h0, led_o};
      SLV_TIMER: rd_mux = tmr_rdata;
      SLV_EINT:  rd_mux = eint_rdata;
      default:   rd_mux = 32'h0;
    endcase
  end

  always_ff @(posedge hb_clk_i) begin
    if (rd_sel_i && !read_finish_o)
      rdata_o <= rd_mux;
  end

  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      read_finish_o <= 1'b0;
    end else begin
      read_finish_o <= rd_sel_i && !read_finish_o;
    end
  end

endmodule

// File: verilog/hb_read_return.sv
`timescale 1ns/10ps

module hb_read_return (
  input  logic                   hb_clk_i,
  input  logic                   rst_n_i,
  input  logic                   read_i,
  input  hb_map_pkg::hb_domain_e rd_dom_i,
  input  logic                   none_rd_i,
  input  logic [31:0]            ram_rdata_i,
  input  logic                   ram_finish_i,
  input  logic [31:0]            loc_rdata_i,
  input  logic                   loc_finish_i,
  output logic [31:0]            rdata_o,
  output logic                   stall_o
);
  import hb_map_pkg::*;

  logic none_finish;
  logic dom_finish;

  // unmapped reads get the same one-cycle finish as a real domain
  always_ff @(posedge hb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      none_finish <= 1'b0;
    end else begin
      none_finish <= none_rd_i && !none_finish;
    end
  end

  always_comb begin
    case (rd_dom_i)
      DOM_RAM: begin
        dom_finish = ram_finish_i;
        rdata_o    = ram_rdata_i;
      end
      DOM_LOCAL: begin
        dom_finish = loc_finish_i;
        rdata_o    = loc_rdata_i;
      end
      default: begin
        dom_finish = none_finish;
        rdata_o    = 32'h0;
      end
    endcase
  end

  assign stall_o = read_i && !dom_finish;

endmodule

// File: verilog/hb_subsys.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module hb_subsys (
  input  logic                        hb_clk_i,
  input  logic                        rst_n_i,
  input  logic                        read_i,
  input  logic                        write_i,
  input  logic [31:0]                 raddr_i,
  input  logic [31:0]                 waddr_i,
  input  logic [31:0]                 wdata_i,
  input  hb_bus_pkg::hb_width_e       write_width_i,
  input  logic                        timer_tick_i,
  input  logic [`HB_EINT_NUM-1:0]     irq_src_i,
  output logic [31:0]                 rdata_o,
  output logic                        stall_o,
  output logic [7:0]                  led_o,
  output logic                        mtimer_int_o,
  output logic                        mextern_int_o,
  output logic [2:0]                  mextern_int_id_o
);
  import hb_map_pkg::*;

  logic       ram_rd_sel, ram_wr_sel;
  logic       loc_rd_sel, loc_wr_sel;
  logic       none_rd;
  hb_slave_e  rd_slave, wr_slave;
  hb_domain_e rd_dom;

  logic [31:0] ram_rdata, loc_rdata;
  logic        ram_finish, loc_finish;

  hb_addr_decode u_hb_addr_decode (
    .hb_clk_i     (hb_clk_i),
    .rst_n_i      (rst_n_i),
    .read_i       (read_i),
    .write_i      (write_i),
    .raddr_i      (raddr_i),
    .waddr_i      (waddr_i),
    .ram_rd_sel_o (ram_rd_sel),
    .ram_wr_sel_o (ram_wr_sel),
    .loc_rd_sel_o (loc_rd_sel),
    .loc_wr_sel_o (loc_wr_sel),
    .rd_slave_o   (rd_slave),
    .wr_slave_o   (wr_slave),
    .rd_dom_o     (rd_dom),
    .none_rd_o    (none_rd)
  );

  hb_data_ram u_hb_data_ram (
    .hb_clk_i      (hb_clk_i),
    .rst_n_i       (rst_n_i),
    .rd_sel_i      (ram_rd_sel),
    .wr_sel_i      (ram_wr_sel),
    .raddr_i       (raddr_i),
    .waddr_i       (waddr_i),
    .wdata_i       (wdata_i),
    .write_width_i (write_width_i),
    .rdata_o       (ram_rdata),
    .read_finish_o (ram_finish)
  );

  hb_local_domain u_hb_local_domain (
    .hb_clk_i         (hb_clk_i),
    .rst_n_i          (rst_n_i),
    .rd_sel_i         (loc_rd_sel),
    .wr_sel_i         (loc_wr_sel),
    .rd_slave_i       (rd_slave),
    .wr_slave_i       (wr_slave),
    .raddr_i          (raddr_i),
    .waddr_i          (waddr_i),
    .wdata_i          (wdata_i),
    .timer_tick_i     (timer_tick_i),
    .irq_src_i        (irq_src_i),
    .rdata_o          (loc_rdata),
    .read_finish_o    (loc_finish),
    .led_o            (led_o),
    .mtimer_int_o     (mtimer_int_o),
    .mextern_int_o    (mextern_int_o),
    .mextern_int_id_o (mextern_int_id_o)
  );

  hb_read_return u_hb_read_return (
    .hb_clk_i     (hb_clk_i),
    .rst_n_i      (rst_n_i),
    .read_i       (read_i),
    .rd_dom_i     (rd_dom),
    .none_rd_i    (none_rd),
    .ram_rdata_i  (ram_rdata),
    .ram_finish_i (ram_finish),
    .loc_rdata_i  (loc_rdata),
    .loc_finish_i (loc_finish),
    .rdata_o      (rdata_o),
    .stall_o      (stall_o)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns bus clock
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset held low for 5 cycles, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

// File: verif/tb_hb_subsys.sv
`timescale 1ns/10ps
`include "hb_defs.svh"

module tb_hb_subsys;
  import hb_bus_pkg::*;

  localparam int N_RAM  = 300;
  localparam int N_LED  = 20;
  localparam int N_TMR  = 200;
  localparam int N_EINT = 200;
  localparam int N_UNM  = 60;
  localparam int N_OPS  = 2 * `HB_RAM_DEPTH + N_RAM + 2 * N_LED + N_TMR + N_EINT + N_UNM + 30;
  localparam logic [31:0] RAM_END   = `HB_DATA_RAM_BASE + 4 * `HB_RAM_DEPTH;
  localparam logic [31:0] LOC_END   = `HB_LOCAL_BASE + 256;
  localparam logic [31:0] TMR_BASE  = `HB_LOCAL_BASE + 32'h40;
  localparam logic [31:0] EINT_BASE = `HB_LOCAL_BASE + 32'h80;

  logic                    hb_clk, rst_n;
  logic                    rd, wr, tick;
  logic [31:0]             raddr, waddr, wdata;
  hb_width_e               wwidth;
  logic [`HB_EINT_NUM-1:0] irq;
  logic [31:0]             rdata;
  logic                    stall, mtimer_int, mextern_int;
  logic [7:0]              led;
  logic [2:0]              mextern_id;

  // reference model state
  logic [31:0]             ram_m [`HB_RAM_DEPTH];
  logic [7:0]              led_m;
  logic [63:0]             mtime_m, mtimecmp_m;
  logic [`HB_EINT_NUM-1:0] pending_m, enable_m;

  logic [31:0] rng;
  int          n_err, n_pass, test_err;
  string       cur_test;

  tb_clk_gen u_clk_gen (
    .clk_o   (hb_clk),
    .rst_n_o (rst_n)
  );

  hb_subsys dut0 (
    .hb_clk_i         (hb_clk),
    .rst_n_i          (rst_n),
    .read_i           (rd),
    .write_i          (wr),
    .raddr_i          (raddr),
    .waddr_i          (waddr),
    .wdata_i          (wdata),
    .write_width_i    (wwidth),
    .timer_tick_i     (tick),
    .irq_src_i        (irq),
    .rdata_o          (rdata),
    .stall_o          (stall),
    .led_o            (led),
    .mtimer_int_o     (mtimer_int),
    .mextern_int_o    (mextern_int),
    .mextern_int_id_o (mextern_id)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      n_err++;
    end else begin
      n_pass++;
    end
  endtask

  // 0 data RAM, 1 local peripherals, 2 unmapped
  function automatic int dom_of(input logic [31:0] addr);
    if (addr >= `HB_DATA_RAM_BASE && addr < RAM_END)
      return 0;
    if (addr >= `HB_LOCAL_BASE && addr < LOC_END)
      return 1;
    return 2;
  endfunction

  function automatic logic [2:0] lowest_active();
    logic [2:0] id;
    logic       found;
    id = 3'd0;
    found = 1'b0;
    for (int i = 0; i < `HB_EINT_NUM; i++) begin
      if (!found && pending_m[i] && enable_m[i]) begin
        id = 3'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (dom_of(addr) == 0)
      return ram_m[(addr - `HB_DATA_RAM_BASE) >> 2];
    if (dom_of(addr) == 2)
      return 32'h0;
    case (addr[7:6])
      2'd0: return {24'h0, led_m};
      2'd1: begin
        case (addr[5:2])
          4'd0:    return mtime_m[31:0];
          4'd1:    return mtime_m[63:32];
          4'd2:    return mtimecmp_m[31:0];
          4'd3:    return mtimecmp_m[63:32];
          default: return 32'h0;
        endcase
      end
      2'd2: begin
        case (addr[5:2])
          4'd0:    return 32'(pending_m);
          4'd1:    return 32'(enable_m);
          4'd2:    return {|(pending_m & enable_m), 28'h0, lowest_active()};
          default: return 32'h0;
        endcase
      end
      default: return 32'h0;
    endcase
  endfunction

  // what the edge that ends the current cycle does to the model
  task automatic apply_edge();
    logic [1:0]              off;
    logic [`HB_EINT_NUM-1:0] clr;
    logic                    mtime_w;
    int                      idx;
    off = waddr[1:0];
    clr = '0;
    mtime_w = 1'b0;
    if (wr && dom_of(waddr) == 0) begin
      idx = (waddr - `HB_DATA_RAM_BASE) >> 2;
      for (int b = 0; b < 4; b++) begin
        case (wwidth)
          W_BYTE:  if (b == off) ram_m[idx][8*b +: 8] = wdata[7:0];
          W_HALF:  if (b / 2 == off[1]) ram_m[idx][8*b +: 8] = wdata[8*(b%2) +: 8];
          default: ram_m[idx][8*b +: 8] = wdata[8*b +: 8];
        endcase
      end
    end else if (wr && dom_of(waddr) == 1) begin
      case (waddr[7:6])
        2'd0: led_m = wdata[7:0];
        2'd1: begin
          mtime_w = (waddr[5:2] == 4'd0) || (waddr[5:2] == 4'd1);
          if (waddr[5:2] == 4'd0) mtime_m[31:0] = wdata;
          if (waddr[5:2] == 4'd1) mtime_m[63:32] = wdata;
          if (waddr[5:2] == 4'd2) mtimecmp_m[31:0] = wdata;
          if (waddr[5:2] == 4'd3) mtimecmp_m[63:32] = wdata;
        end
        2'd2: begin
          if (waddr[5:2] == 4'd0) clr = wdata[`HB_EINT_NUM-1:0];
          if (waddr[5:2] == 4'd1) enable_m = wdata[`HB_EINT_NUM-1:0];
        end
        default: ;
      endcase
    end
    if (tick && !mtime_w)
      mtime_m = mtime_m + 64'd1;
    pending_m = (pending_m & ~clr) | irq;
  endtask

  // drives one bus cycle 2 ns after the edge and samples it at mid cycle
  task automatic cycle(input logic rd_v, input logic [31:0] ra, input logic wr_v,
                       input logic [31:0] wa, input logic [31:0] wd, input hb_width_e ww);
    logic [31:0] r;
    @(posedge hb_clk);
    apply_edge();
    #2;
    r = next_rand();
    rd = rd_v;
    raddr = ra;
    wr = wr_v;
    waddr = wa;
    wdata = wd;
    wwidth = ww;
    tick = r[0];
    // sparse irq pulses
    irq = r[15:8] & r[23:16] & r[31:24];
    #18;
    check_val({cur_test, " mtimer_int_o"}, 32'(mtime_m >= mtimecmp_m), 32'(mtimer_int));
    check_val({cur_test, " mextern_int_o"}, 32'(|(pending_m & enable_m)), 32'(mextern_int));
    check_val({cur_test, " mextern_int_id_o"}, 32'(lowest_active()), 32'(mextern_id));
    check_val({cur_test, " led_o"}, 32'(led_m), 32'(led));
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input hb_width_e ww);
    cycle(1'b0, 32'h0, 1'b1, addr, data, ww);
  endtask

  task automatic do_read(input logic [31:0] addr, input string name);
    logic [31:0] exp;
    int          stalls;
    cycle(1'b1, addr, 1'b0, 32'h0, 32'h0, W_WORD);
    exp = model_read(addr);
    stalls = 0;
    while (stall && stalls < 2) begin
      stalls++;
      cycle(1'b1, addr, 1'b0, 32'h0, 32'h0, W_WORD);
    end
    if (stall) begin
      $display("stall_o stayed high for more than two cycles in test %s, read of %h",
               cur_test, addr);
      n_err++;
    end else begin
      check_val({cur_test, " ", name, " stall cycles"}, 32'd1, 32'(stalls));
      check_val({cur_test, " ", name}, exp, rdata);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = n_err;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", cur_test, n_err - test_err);
  endtask

  initial begin
    #((N_OPS * 4 + 100) * 40);
    $display("watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r, a;
    logic [1:0]  w;
    rng = 32'h842c;
    n_err = 0;
    n_pass = 0;
    rd = 1'b0;
    wr = 1'b0;
    raddr = 32'h0;
    waddr = 32'h0;
    wdata = 32'h0;
    wwidth = W_WORD;
    tick = 1'b0;
    irq = '0;
    led_m = 8'h0;
    mtime_m = 64'h0;
    mtimecmp_m = '1;
    pending_m = '0;
    enable_m = '0;
    wait (rst_n === 1'b1);

    start_test("reset");
    check_val("reset stall_o", 32'h0, 32'(stall));
    check_val("reset led_o", 32'h0, 32'(led));
    check_val("reset mtimer_int_o", 32'h0, 32'(mtimer_int));
    check_val("reset mextern_int_o", 32'h0, 32'(mextern_int));
    do_read(TMR_BASE + 32'h8, "mtimecmp lo");
    do_read(TMR_BASE + 32'hc, "mtimecmp hi");
    end_test();

    start_test("ram");
    for (int i = 0; i < `HB_RAM_DEPTH; i++)
      do_write(`HB_DATA_RAM_BASE + 4 * i, i * 32'h9e37_79b1 + 32'h1234_5678, W_WORD);
    for (int i = 0; i < N_RAM; i++) begin
      r = next_rand();
      a = `HB_DATA_RAM_BASE + r[9:0];
      w = (r[13:12] == 2'd3) ? 2'd2 : r[13:12];
      if (r[31])
        do_read({a[31:2], 2'b00}, "ram word");
      else
        do_write(a, next_rand(), hb_width_e'(w));
    end
    end_test();

    start_test("led");
    for (int i = 0; i < N_LED; i++) begin
      r = next_rand();
      do_write(`HB_LOCAL_BASE + {r[5:2], 2'b00}, next_rand(), W_WORD);
      do_read(`HB_LOCAL_BASE, "led readback");
    end
    end_test();

    start_test("timer");
    for (int i = 0; i < N_TMR; i++) begin
      r = next_rand();
      // small values so that mtime crosses mtimecmp both ways
      if (r[4])
        do_write(TMR_BASE + {r[1:0], 2'b00}, r[0] ? {31'h0, r[8]} : {23'h0, r[28:20]}, W_WORD);
      else
        do_read(TMR_BASE + {r[1:0], 2'b00}, "timer reg");
    end
    end_test();

    start_test("eint");
    for (int i = 0; i < N_EINT; i++) begin
      r = next_rand();
      w = (r[4:3] == 2'd3) ? 2'd2 : r[4:3];
      if (r[2:0] < 3'd2)
        do_write(EINT_BASE + 32'h4, next_rand(), W_WORD);
      else if (r[2:0] < 3'd4)
        do_write(EINT_BASE, next_rand(), W_WORD);
      else
        do_read(EINT_BASE + {w, 2'b00}, "eint reg");
    end
    end_test();

    start_test("unmapped");
    for (int i = 0; i < N_UNM; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    a = RAM_END + {r[11:4], 2'b00};
        2'd1:    a = LOC_END + {r[11:4], 2'b00};
        default: a = r | 32'h8000_0000;
      endcase
      if (r[2])
        do_read(a, "unmapped read");
      else
        do_write(a, next_rand(), W_WORD);
    end
    // every RAM word, so that any aliased write shows up
    for (int i = 0; i < `HB_RAM_DEPTH; i++)
      do_read(`HB_DATA_RAM_BASE + 4 * i, "ram after unmapped");
    do_read(`HB_LOCAL_BASE, "led after unmapped");
    do_read(TMR_BASE + 32'h8, "mtimecmp after unmapped");
    do_read(EINT_BASE + 32'h4, "enable after unmapped");
    end_test();

    $display("checks passed: %0d, errors: %0d", n_pass, n_err);
    if (n_err == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hb_subsys.f
+incdir+common
common/hb_bus_pkg.sv
common/hb_map_pkg.sv
verilog/hb_addr_decode.sv
verilog/hb_data_ram.sv
hb_local/system_timer.sv
hb_local/eint_ctrl.sv
hb_local/hb_local_domain.sv
verilog/hb_read_return.sv
verilog/hb_subsys.sv
verif/tb_clk_gen.sv
verif/tb_hb_subsys.sv
